//--- source/dma_pkg.sv
package dma_pkg;

	// ----------------------------------------------------------------------
	// Basic widths
	// ----------------------------------------------------------------------

	typedef logic [7:0]  byte_t;            // One data byte off the SPI bus
	typedef logic [15:0] addr_t;            // Buffer address, RAM keeps only the low bits
	typedef logic [3:0]  block_count_t;     // Blocks per request, zero means nothing to do
	typedef logic [15:0] crc_t;             // CRC-16 value

	// ----------------------------------------------------------------------
	// Buffer write port
	// ----------------------------------------------------------------------

	// One byte into the buffer, also seen by the CRC unit
	typedef struct packed {
		logic  en;                          // Single-cycle write strobe
		addr_t addr;                        // Target location
		byte_t data;                        // Byte from the SPI engine
	} ram_write_t;

	// ----------------------------------------------------------------------
	// Sequencer states
	// ----------------------------------------------------------------------

	typedef enum logic [2:0] {
		IDLE,                               // Bus free, waiting for a request
		REQUEST,                            // Kick the SPI engine for one byte
		WAIT_BYTE,                          // Byte in flight
		BLOCK_END,                          // Next block or finish
		DONE                                // Hand the buffer back
	} dma_state_t;

endpackage

//--- source/spi_master.sv
`timescale 1ns/1ps

// Mode-0 SPI byte exchanger, receive only
// Clock idles low, miso is sampled on rising sclk edges, MSB first
module spi_master
	import dma_pkg::*;
#(
	parameter int CLK_DIV = 4               // clk cycles per sclk half-period
)
(
	input  logic  clk,
	input  logic  reset_n,
	input  logic  byte_start,               // Strobe, begins one 8-bit exchange
	input  logic  miso,
	input  logic  select,                   // Registered chip select from the sequencer
	output logic  byte_done,                // Strobe, rx_byte valid in this cycle
	output byte_t rx_byte,
	output logic  sclk,
	output logic  mosi,
	output logic  cs_n
);

	localparam int DIV_W = $clog2(CLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

	logic             active;               // Byte exchange in progress
	logic [DIV_W-1:0] div_cnt;              // Half-period timer
	logic [2:0]       bit_cnt;              // Bits completed in this byte
	logic             half_end;             // Last clk cycle of a half-period
	byte_t            shift;                // Receive shift register

	assign half_end = active && (div_cnt == DIV_LAST);

	// Card sees all ones while we read
	assign mosi = 1'b1;

	// Select is already registered upstream
	assign cs_n = ~select;

	assign rx_byte = shift;

	// ----------------------------------------------------------------------
	// Clock generation and bit counting
	// ----------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			active    <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			sclk      <= 1'b0;
			byte_done <= 1'b0;
		end
		else
		begin
			byte_done <= 1'b0;                              // Strobe by default

			if (!active)
			begin
				if (byte_start)
				begin
					active  <= 1'b1;
					div_cnt <= '0;
					bit_cnt <= '0;
				end
			end
			else if (half_end)
			begin
				div_cnt <= '0;
				sclk    <= ~sclk;                           // Toggle every half-period

				// Falling edge closes a bit
				if (sclk)
				begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
					begin
						active    <= 1'b0;                  // Eighth falling edge, byte over
						byte_done <= 1'b1;
					end
				end
			end
			else
				div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	// ----------------------------------------------------------------------
	// Receive data path
	// ----------------------------------------------------------------------

	// Shift in on the clk edge that raises sclk, miso is stable here
	always_ff @(posedge clk)
	begin
		if (half_end && !sclk)
			shift <= {shift[6:0], miso};                    // MSB arrives first
	end

endmodule

//--- source/dma_read.sv
`timescale 1ns/1ps

// Block-read sequencer
// Pulls raw bytes from the SPI engine and writes them in order into the buffer
// While ready is low the buffer belongs to this block
module dma_read
	import dma_pkg::*;
#(
	parameter int BLOCK_BYTES = 512         // Bytes per block
)
(
	input  logic         clk,
	input  logic         reset_n,
	input  logic         start,             // Host request strobe
	input  addr_t        base_addr,         // First buffer location of the transfer
	input  block_count_t nblocks,           // Zero is ignored
	input  logic         byte_done,         // From the SPI engine
	input  byte_t        rx_byte,
	output logic         ready,             // High when idle
	output logic         byte_start,        // To the SPI engine
	output logic         select,            // Chip select, high for the whole transfer
	output ram_write_t   wr,                // Buffer and CRC write stream
	output logic         block_last         // With wr.en of the final byte of a block
);

	localparam int CNT_W = $clog2(BLOCK_BYTES + 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(BLOCK_BYTES);
	localparam logic [CNT_W-1:0] CNT_ONE  = CNT_W'(1);

	dma_state_t       state;
	logic             busy;                 // Transfer owns the buffer
	block_count_t     blocks_left;          // Including the current one
	logic [CNT_W-1:0] byte_cnt;             // Bytes still due in this block
	addr_t            next_addr;            // Where the next byte goes

	// Write port registers
	logic             wr_en;
	addr_t            wr_addr;
	byte_t            wr_data;

	logic             accept;               // Valid request seen in IDLE
	logic             take_byte;            // Byte arrived while waiting

	assign accept    = (state == IDLE) && start && (nblocks != '0);
	assign take_byte = (state == WAIT_BYTE) && byte_done;

	assign ready  = ~busy;
	assign select = busy;

	assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};

	// ----------------------------------------------------------------------
	// Control FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state       <= IDLE;
			busy        <= 1'b0;
			blocks_left <= '0;
			byte_cnt    <= '0;
			byte_start  <= 1'b0;
			wr_en       <= 1'b0;
			block_last  <= 1'b0;
		end
		else
		begin
			// Strobes fall back unless set below
			byte_start <= 1'b0;
			wr_en      <= 1'b0;
			block_last <= 1'b0;

			case (state)
				IDLE:
				begin
					if (accept)
					begin
						blocks_left <= nblocks;
						byte_cnt    <= CNT_FULL;
						busy        <= 1'b1;                // ready drops next cycle
						state       <= REQUEST;
					end
				end

				REQUEST:
				begin
					byte_start <= 1'b1;                     // One byte please
					state      <= WAIT_BYTE;
				end

				WAIT_BYTE:
				begin
					// No timeout, the SPI engine always finishes
					if (byte_done)
					begin
						wr_en      <= 1'b1;
						block_last <= (byte_cnt == CNT_ONE);
						byte_cnt   <= byte_cnt - CNT_ONE;
						if (byte_cnt == CNT_ONE)
							state <= BLOCK_END;             // Block complete
						else
							state <= REQUEST;               // More bytes in this block
					end
				end

				BLOCK_END:
				begin
					byte_cnt <= CNT_FULL;                   // Reload for the next block
					if (blocks_left != block_count_t'(1))
					begin
						blocks_left <= blocks_left - block_count_t'(1);
						state       <= REQUEST;
					end
					else
						state <= DONE;
				end

				DONE:
				begin
					busy        <= 1'b0;                    // Host may read the buffer now
					blocks_left <= '0;
					state       <= IDLE;
				end

				default:
					state <= IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Address and data path
	// ----------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (accept)
			next_addr <= base_addr;                         // Running address starts at base
		if (take_byte)
		begin
			wr_addr   <= next_addr;
			wr_data   <= rx_byte;
			next_addr <= next_addr + addr_t'(1);            // Wraps in the RAM's low bits
		end
	end

endmodule

//--- source/buffer_ram.sv
`timescale 1ns/1ps

// Transfer buffer
// One write port from the DMA, one registered read port for the host
module buffer_ram
	import dma_pkg::*;
#(
	parameter int ADDR_WIDTH = 12           // Depth in address bits
)
(
	input  logic       clk,
	input  ram_write_t wr,                  // Write stream from the sequencer
	input  addr_t      rd_addr,             // Host read address
	output byte_t      rd_data              // One cycle after rd_addr
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	byte_t                 mem [DEPTH];     // Storage
	logic [ADDR_WIDTH-1:0] wr_index;
	logic [ADDR_WIDTH-1:0] rd_index;

	// Upper address bits fold away
	assign wr_index = wr.addr[ADDR_WIDTH-1:0];
	assign rd_index = rd_addr[ADDR_WIDTH-1:0];

	// ----------------------------------------------------------------------
	// Write port
	// ----------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (wr.en)
			mem[wr_index] <= wr.data;
	end

	// ----------------------------------------------------------------------
	// Read port
	// ----------------------------------------------------------------------

	// Registered output, maps onto block RAM
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_index];
	end

endmodule

//--- source/block_crc16.sv
`timescale 1ns/1ps

// Per-block CRC-16/CCITT over the buffer write stream
// Polynomial 0x1021, initial value zero, as used on SD data blocks
module block_crc16
	import dma_pkg::*;
#(
	parameter int BLOCK_BYTES = 512         // Bytes per block
)
(
	input  logic         clk,
	input  logic         reset_n,
	input  logic         start,             // Accepted transfer, restarts block numbering
	input  ram_write_t   wr,                // Same stream the buffer sees
	input  logic         block_last,        // Final byte of a block
	output logic         crc_valid,         // Strobe, crc and crc_block valid
	output crc_t         crc,
	output block_count_t crc_block          // Block index inside the transfer
);

	localparam int   POS_W    = $clog2(BLOCK_BYTES);
	localparam crc_t CRC_POLY = 16'h1021;
	localparam crc_t CRC_INIT = 16'h0000;

	crc_t             acc;                  // Running CRC of the current block
	crc_t             crc_next;
	logic [POS_W-1:0] byte_pos;             // Position inside the block
	block_count_t     blk_idx;              // Index of the block being summed

	// Bitwise update, MSB of the byte first
	function automatic crc_t crc_update(input crc_t seed, input byte_t data);
		crc_t c;
		logic fb;
		c = seed;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[15] ^ data[i];
			c  = {c[14:0], 1'b0};
			if (fb)
				c = c ^ CRC_POLY;
		end
		return c;
	endfunction

	// First byte of a block starts from the init value
	assign crc_next = crc_update((byte_pos == '0) ? CRC_INIT : acc, wr.data);

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			crc_valid <= 1'b0;
			byte_pos  <= '0;
			blk_idx   <= '0;
			crc_block <= '0;
		end
		else
		begin
			crc_valid <= 1'b0;
			if (start)
			begin
				blk_idx  <= '0;                             // New transfer counts from zero
				byte_pos <= '0;
			end
			if (wr.en)
			begin
				if (block_last)
				begin
					byte_pos  <= '0;
					crc_valid <= 1'b1;
					crc_block <= blk_idx;
					blk_idx   <= blk_idx + block_count_t'(1);
				end
				else
					byte_pos <= byte_pos + POS_W'(1);
			end
		end
	end

	// Result registers
	always_ff @(posedge clk)
	begin
		if (wr.en)
			acc <= crc_next;
		if (wr.en && block_last)
			crc <= crc_next;                                // Held until the next block ends
	end

endmodule

//--- source/dma_top.sv
`timescale 1ns/1ps

// Block-read DMA subsystem
// SPI byte engine feeds the sequencer, which fills the buffer and the CRC unit
module dma_top
	import dma_pkg::*;
#(
	parameter int CLK_DIV     = 4,          // clk cycles per sclk half-period
	parameter int BLOCK_BYTES = 512,        // Bytes per block
	parameter int ADDR_WIDTH  = 12          // Buffer depth in address bits
)
(
	input  logic         clk,
	input  logic         reset_n,

	// Host request and status
	input  logic         start,
	input  addr_t        base_addr,
	input  block_count_t nblocks,
	output logic         ready,

	// Host buffer read
	input  addr_t        rd_addr,
	output byte_t        rd_data,

	// Block checksums
	output logic         crc_valid,
	output crc_t         crc,
	output block_count_t crc_block,

	// SPI pins
	output logic         sclk,
	output logic         mosi,
	output logic         cs_n,
	input  logic         miso
);

	// ----------------------------------------------------------------------
	// Internal links
	// ----------------------------------------------------------------------

	logic       byte_start;                 // Sequencer to SPI
	logic       byte_done;                  // SPI to sequencer
	byte_t      rx_byte;
	logic       select;
	ram_write_t wr;                         // Write stream to buffer and CRC
	logic       block_last;
	logic       xfer_start;                 // Request the sequencer will take

	// Only a request that starts a transfer restarts block numbering
	assign xfer_start = start & ready & (nblocks != '0);

	// ----------------------------------------------------------------------
	// Blocks
	// ----------------------------------------------------------------------

	spi_master #(.CLK_DIV(CLK_DIV)) spi0 (
		.clk        (clk),
		.reset_n    (reset_n),
		.byte_start (byte_start),
		.miso       (miso),
		.select     (select),
		.byte_done  (byte_done),
		.rx_byte    (rx_byte),
		.sclk       (sclk),
		.mosi       (mosi),
		.cs_n       (cs_n)
	);

	dma_read #(.BLOCK_BYTES(BLOCK_BYTES)) dma0 (
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (start),
		.base_addr  (base_addr),
		.nblocks    (nblocks),
		.byte_done  (byte_done),
		.rx_byte    (rx_byte),
		.ready      (ready),
		.byte_start (byte_start),
		.select     (select),
		.wr         (wr),
		.block_last (block_last)
	);

	buffer_ram #(.ADDR_WIDTH(ADDR_WIDTH)) ram0 (
		.clk        (clk),
		.wr         (wr),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

	block_crc16 #(.BLOCK_BYTES(BLOCK_BYTES)) crc0 (
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (xfer_start),
		.wr         (wr),
		.block_last (block_last),
		.crc_valid  (crc_valid),
		.crc        (crc),
		.crc_block  (crc_block)
	);

endmodule

//--- tb/dma_assertions.sv
`timescale 1ns/1ps

// Protocol checks on the block-read sequencer
module dma_assertions
	import dma_pkg::*;
(
	input logic         clk,
	input logic         reset_n,
	input logic         start,
	input block_count_t nblocks,
	input logic         ready,
	input logic         byte_start,
	input ram_write_t   wr,
	input dma_state_t   state
);

	// Buffer writes only inside a transfer
	assert property (@(posedge clk) disable iff (!reset_n) wr.en |-> !ready)
		else $error("buffer write while ready is high");

	// byte_start shows up only in the first cycle after REQUEST
	assert property (@(posedge clk) disable iff (!reset_n)
		(state == WAIT_BYTE && $past(state) == WAIT_BYTE) |-> !byte_start)
		else $error("byte_start while a byte is in flight");

	// Accepted request takes the bus on the next cycle
	assert property (@(posedge clk) disable iff (!reset_n)
		(start && ready && nblocks != '0) |=> !ready)
		else $error("ready still high one cycle after a valid start");

	// Write strobes never back to back
	assert property (@(posedge clk) disable iff (!reset_n) wr.en |=> !wr.en)
		else $error("two buffer writes in consecutive cycles");

endmodule

bind dma_read dma_assertions asrt0 (
	.clk        (clk),
	.reset_n    (reset_n),
	.start      (start),
	.nblocks    (nblocks),
	.ready      (ready),
	.byte_start (byte_start),
	.wr         (wr),
	.state      (state)
);

//--- tb/dma_tb.sv
`timescale 1ns/1ps

module dma_tb
	import dma_pkg::*;
();

	localparam int CLK_DIV     = 2;
	localparam int BLOCK_BYTES = 16;
	localparam int ADDR_WIDTH  = 8;
	localparam int DEPTH       = 256;       // 2 ** ADDR_WIDTH
	localparam int WAIT_LIMIT  = 4000;      // Cycles allowed for one transfer
	localparam int DRIVE_DELAY = 2;         // ns after the clock edge

	logic clk, reset_n, start, miso;
	addr_t base_addr, rd_addr;
	block_count_t nblocks;
	logic ready, crc_valid, sclk, mosi, cs_n;
	byte_t rd_data;
	crc_t crc;
	block_count_t crc_block;

	integer seed = 32'hb5197246;
	int checks = 0;
	int errors = 0;

	byte_t tx_byte;                         // Byte the device is shifting out
	int    bit_idx;
	byte_t sent_bytes [$];                  // Bytes fully clocked out this transfer
	crc_t  crc_seen [$];                    // crc_valid strobes as seen
	block_count_t blk_seen [$];
	byte_t shadow [DEPTH];                  // Expected buffer contents
	bit    written [DEPTH];                 // Locations that hold known data

	dma_top #(.CLK_DIV(CLK_DIV), .BLOCK_BYTES(BLOCK_BYTES), .ADDR_WIDTH(ADDR_WIDTH)) dut0 (
		.clk(clk), .reset_n(reset_n), .start(start), .base_addr(base_addr),
		.nblocks(nblocks), .ready(ready), .rd_addr(rd_addr), .rd_data(rd_data),
		.crc_valid(crc_valid), .crc(crc), .crc_block(crc_block),
		.sclk(sclk), .mosi(mosi), .cs_n(cs_n), .miso(miso)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;             // 40 ns period
	end

	// ----------------------------------------------------------------------
	// Checking helpers
	// ----------------------------------------------------------------------

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAILED %0t %s actual %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic timeout_abort(input string what);
		$display("ERROR at %0t: timed out, %s", $time, what);
		$display("tests failed");
		$finish;
	endtask

	// Bytewise CRC-16/CCITT, poly 0x1021, init 0
	function automatic crc_t block_crc_model(input int first);
		crc_t c;
		int k;
		int b;
		c = 16'h0000;
		for (k = first; k < first + BLOCK_BYTES; k++)
		begin
			c = c ^ {sent_bytes[k], 8'h00};
			for (b = 0; b < 8; b++)
				c = c[15] ? ((c << 1) ^ 16'h1021) : (c << 1);
		end
		return c;
	endfunction

	// ----------------------------------------------------------------------
	// SPI device model, mode 0
	// ----------------------------------------------------------------------

	task automatic load_device_byte();
		tx_byte = byte_t'($random(seed));
		bit_idx = 0;
		miso    = tx_byte[7];               // MSB ready before the first rising sclk
	endtask

	initial
	begin
		miso = 1'b1;
		forever
		begin
			@(negedge cs_n);
			#1;
			load_device_byte();
			while (cs_n === 1'b0)
			begin
				@(negedge sclk or posedge cs_n);
				#1;
				if (cs_n === 1'b0)
				begin
					bit_idx++;                                  // Change data on falling sclk
					if (bit_idx == 8)
					begin
						sent_bytes.push_back(tx_byte);          // All bits sampled by now
						load_device_byte();
					end
					else
						miso = tx_byte[7 - bit_idx];
				end
			end
			miso = 1'b1;                                        // Bus idle
		end
	end

	// CRC strobe monitor, sampled mid-cycle
	always @(negedge clk)
	begin
		if (reset_n === 1'b1 && crc_valid === 1'b1)
		begin
			crc_seen.push_back(crc);
			blk_seen.push_back(crc_block);
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus tasks
	// ----------------------------------------------------------------------

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (ready !== 1'b1)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				timeout_abort("ready did not return after a transfer");
		end
	endtask

	// Returns just after the rising edge that follows the first CRC strobe
	task automatic wait_first_crc();
		int cycles;
		cycles = 0;
		while (crc_seen.size() == 0)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				timeout_abort("no CRC strobe during a transfer");
		end
	endtask

	// Read back every known location through the host port
	task automatic verify_buffer();
		for (int a = 0; a < DEPTH; a++)
		begin
			if (written[a])
			begin
				@(posedge clk);
				#DRIVE_DELAY rd_addr = addr_t'(a);
				@(posedge clk);                             // rd_data registered here
				@(negedge clk);
				compare_value($sformatf("rd_data[%0d]", a), rd_data, shadow[a]);
			end
		end
	endtask

	// Requests that must be dropped, buffer and CRC count stay put
	task automatic idle_request();
		sent_bytes.delete();
		crc_seen.delete();
		@(posedge clk);
		#DRIVE_DELAY start = 1'b1;
		nblocks   = '0;
		base_addr = addr_t'($random(seed));
		@(posedge clk);
		#DRIVE_DELAY start = 1'b0;
		compare_value("ready", ready, 1'b1);
		repeat (40) @(posedge clk);
		compare_value("cs_n", cs_n, 1'b1);
		compare_value("crc strobes", crc_seen.size(), 0);
		compare_value("bytes read", sent_bytes.size(), 0);
		verify_buffer();
	endtask

	task automatic run_transfer(input addr_t base, input block_count_t nb);
		int k;
		int blk;
		int idx;
		sent_bytes.delete();
		crc_seen.delete();
		blk_seen.delete();
		@(posedge clk);
		#DRIVE_DELAY start = 1'b1;
		base_addr = base;
		nblocks   = nb;
		@(posedge clk);
		#DRIVE_DELAY start = 1'b0;
		base_addr = addr_t'($random(seed));                 // Must have been latched
		compare_value("ready", ready, 1'b0);
		compare_value("cs_n", cs_n, 1'b0);

		// Start while busy is ignored, after a block has closed when there is a next one
		if (nb > 1)
			wait_first_crc();
		else
			repeat (3) @(posedge clk);
		#DRIVE_DELAY start = 1'b1;
		nblocks = 4'd5;
		@(posedge clk);
		#DRIVE_DELAY start = 1'b0;
		compare_value("mosi", mosi, 1'b1);                  // Card sees all ones

		wait_ready();
		compare_value("bytes read", sent_bytes.size(), nb * BLOCK_BYTES);
		for (k = 0; k < sent_bytes.size(); k++)
		begin
			idx = (int'(base) + k) % DEPTH;                 // Wraps in the 8-bit buffer
			shadow[idx]  = sent_bytes[k];
			written[idx] = 1'b1;
		end

		compare_value("crc strobes", crc_seen.size(), nb);
		for (blk = 0; blk < crc_seen.size() && blk < nb; blk++)
		begin
			compare_value("crc_block", blk_seen[blk], blk);
			if ((blk + 1) * BLOCK_BYTES <= sent_bytes.size())
				compare_value("crc", crc_seen[blk], block_crc_model(blk * BLOCK_BYTES));
		end
		verify_buffer();
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------

	initial
	begin
		addr_t base;
		block_count_t nb;
		reset_n   = 1'b0;
		start     = 1'b0;
		base_addr = '0;
		nblocks   = '0;
		rd_addr   = '0;
		repeat (16) @(posedge clk);
		#DRIVE_DELAY reset_n = 1'b1;
		@(negedge clk);
		compare_value("ready", ready, 1'b1);
		compare_value("cs_n", cs_n, 1'b1);
		compare_value("sclk", sclk, 1'b0);
		compare_value("crc_valid", crc_valid, 1'b0);

		idle_request();
		run_transfer(16'h00f8, 4'd2);                       // Crosses address 255
		for (int i = 0; i < 8; i++)
		begin
			base = addr_t'($random(seed));
			nb   = block_count_t'(1 + ($unsigned($random(seed)) % 3));
			run_transfer(base, nb);
		end
		idle_request();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- sim.f
source/dma_pkg.sv
source/spi_master.sv
source/dma_read.sv
source/buffer_ram.sv
source/block_crc16.sv
source/dma_top.sv
tb/dma_assertions.sv
tb/dma_tb.sv
